// ==== Bender.yml ====
package:
  name: alu_pipeline

sources:
  - alu_pkg.sv
  - alu_dec_if.sv
  - alu_res_if.sv
  - alu_decode_stage.sv
  - ripple_adder.sv
  - alu_execute_stage.sv
  - alu_flag_stage.sv
  - alu_pipeline.sv
  - target: test
    files:
      - tb_alu_pipeline.sv

// ==== alu_dec_if.sv ====
interface alu_dec_if;

    logic               valid;
    alu_pkg::opcode_t   op;
    alu_pkg::word_t     a;
    alu_pkg::word_t     b;
    logic               invert_a;   // Adder sees ~a.
    alu_pkg::addb_sel_t addb_sel;
    logic               carry_in;
    logic               arith;      // V and C are meaningful.
    logic               shift;      // Z and N are suppressed.

    modport dec_mp (
        output valid, op, a, b,
        output invert_a, addb_sel, carry_in,
        output arith, shift
    );

    modport ex_mp (
        input  valid, op, a, b,
        input  invert_a, addb_sel, carry_in,
        input  arith, shift
    );

endinterface

// ==== alu_decode_stage.sv ====
module alu_decode_stage (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             valid_i,
    input  alu_pkg::opcode_t op_i,
    input  alu_pkg::word_t   a_i,
    input  alu_pkg::word_t   b_i,
    alu_dec_if.dec_mp        dec_o
);

    logic               invert_a;
    alu_pkg::addb_sel_t addb_sel;
    logic               carry_in;
    logic               arith;
    logic               shift;

    // Opcode groups are resolved here once.
    always_comb begin
        invert_a = (op_i == alu_pkg::OP_NEG) || (op_i == alu_pkg::OP_MOD4);
        carry_in = (op_i == alu_pkg::OP_SUB);
        shift    = (op_i == alu_pkg::OP_LSL) || (op_i == alu_pkg::OP_ASR);
        arith    = op_i inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_INC,
                                alu_pkg::OP_DEC, alu_pkg::OP_NEG};

        case (op_i)
            alu_pkg::OP_ADD: addb_sel = alu_pkg::ADDB_B;
            alu_pkg::OP_SUB: addb_sel = alu_pkg::ADDB_NOT_B;      // a + ~b + 1.
            alu_pkg::OP_DEC: addb_sel = alu_pkg::ADDB_ALL_ONES;
            default:         addb_sel = alu_pkg::ADDB_ONE;        // INC, NEG, MOD4.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_o.op       <= op_i;
        dec_o.a        <= a_i;
        dec_o.b        <= b_i;
        dec_o.invert_a <= invert_a;
        dec_o.addb_sel <= addb_sel;
        dec_o.carry_in <= carry_in;
        dec_o.arith    <= arith;
        dec_o.shift    <= shift;
    end

endmodule

// ==== alu_execute_stage.sv ====
module alu_execute_stage (
    input  logic      clk_i,
    input  logic      reset_i,
    alu_dec_if.ex_mp  dec_i,
    alu_res_if.ex_mp  res_o
);

    alu_pkg::word_t  add_a;
    alu_pkg::word_t  add_b;
    alu_pkg::word_t  sum;
    alu_pkg::carry_t carries;

    alu_pkg::word_t  not_res;
    alu_pkg::word_t  and_res;
    alu_pkg::word_t  xnor_res;
    alu_pkg::word_t  lsl_res;
    alu_pkg::word_t  asr_res;
    alu_pkg::word_t  mul8_res;
    alu_pkg::word_t  mod4_res;
    alu_pkg::word_t  result;

    assign add_a = dec_i.invert_a ? ~dec_i.a : dec_i.a;

    always_comb begin
        case (dec_i.addb_sel)
            alu_pkg::ADDB_B:     add_b = dec_i.b;
            alu_pkg::ADDB_NOT_B: add_b = ~dec_i.b;
            alu_pkg::ADDB_ONE:   add_b = 8'h01;
            default:             add_b = 8'hff;
        endcase
    end

    ripple_adder u_ripple_adder (
        .a_i       (add_a),
        .b_i       (add_b),
        .carry_i   (dec_i.carry_in),
        .sum_o     (sum),
        .carries_o (carries)
    );

    assign not_res  = ~dec_i.a;
    assign and_res  = dec_i.a & dec_i.b;
    assign xnor_res = ~(dec_i.a ^ dec_i.b);
    assign lsl_res  = {dec_i.b[6:0], 1'b0};
    assign asr_res  = {dec_i.b[7], dec_i.b[7:1]};   // Sign fill.
    assign mul8_res = {dec_i.b[4:0], 3'b000};

    // Negative a takes the low bits of -a from the adder.
    assign mod4_res = {6'b0, dec_i.a[7] ? sum[1:0] : dec_i.a[1:0]};

    always_comb begin
        case (dec_i.op)
            alu_pkg::OP_NOT:    result = not_res;
            alu_pkg::OP_AND:    result = and_res;
            alu_pkg::OP_XNOR:   result = xnor_res;
            alu_pkg::OP_LSL:    result = lsl_res;
            alu_pkg::OP_ASR:    result = asr_res;
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB,
            alu_pkg::OP_INC,
            alu_pkg::OP_DEC,
            alu_pkg::OP_NEG:    result = sum;
            alu_pkg::OP_MULTI8: result = mul8_res;
            alu_pkg::OP_MOD4:   result = mod4_res;
            default:            result = '0;        // Unused codes.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= dec_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_o.result  <= result;
        res_o.carries <= carries;
        res_o.arith   <= dec_i.arith;
        res_o.shift   <= dec_i.shift;
    end

endmodule

// ==== alu_flag_stage.sv ====
module alu_flag_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    alu_res_if.flg_mp         res_i,
    output logic              valid_o,
    output alu_pkg::word_t    result_o,
    output alu_pkg::status_t  status_o
);

    logic             overflow;
    logic             carry_out;
    logic             zero;
    logic             negative;
    alu_pkg::status_t status;

    // Adder flags only for arithmetic ops.
    assign overflow  = res_i.arith & (res_i.carries[7] ^ res_i.carries[6]);
    assign carry_out = res_i.arith & res_i.carries[7];

    // Result flags, masked for shifts.
    assign zero     = ~res_i.shift & (res_i.result == '0);
    assign negative = ~res_i.shift & res_i.result[7];

    always_comb begin
        status                 = '0;
        status[alu_pkg::FLAG_V] = overflow;
        status[alu_pkg::FLAG_Z] = zero;
        status[alu_pkg::FLAG_C] = carry_out;
        status[alu_pkg::FLAG_N] = negative;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            status_o <= '0;
        end else begin
            valid_o <= res_i.valid;
            if (res_i.valid) begin     // Hold last result between ops.
                result_o <= res_i.result;
                status_o <= status;
            end
        end
    end

endmodule

// ==== alu_golden.txt ====
// Columns in hex: opcode a b result status
// Status bits from 3 down: V Z C N
0 00 00 ff 1
0 ff 12 00 4
0 5a 00 a5 1
1 f0 0f 00 4
1 c3 a5 81 1
1 3c 7e 3c 0
2 aa 55 00 4
2 12 34 d9 1
2 ff ff ff 1
3 33 81 02 0
3 00 40 80 0
3 c5 80 00 0
4 12 80 c0 0
4 00 01 00 0
4 ff 7e 3f 0
5 7f 01 80 9
5 ff 01 00 6
5 80 80 00 e
5 12 34 46 0
6 00 00 00 6
6 80 01 7f a
6 05 03 02 2
6 03 05 fe 1
7 ff 00 00 6
7 41 9c 42 0
8 80 00 7f a
8 00 00 ff 1
8 01 55 00 6
9 80 00 80 9
9 00 00 00 6
9 05 ff fb 1
a 00 11 88 1
a ff 20 00 4
a 00 0f 78 0
b 07 00 03 0
b fd 00 03 0
b 80 00 00 4
b fa 00 02 0
b 04 00 00 4
c 12 34 00 4
d ff ff 00 4
e 80 7f 00 4
f 55 aa 00 4

// ==== alu_pipeline.sv ====
module alu_pipeline (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  alu_pkg::opcode_t  op_i,
    input  alu_pkg::word_t    a_i,
    input  alu_pkg::word_t    b_i,
    output logic              valid_o,
    output alu_pkg::word_t    result_o,
    output alu_pkg::status_t  status_o
);

    alu_dec_if dec_if ();
    alu_res_if res_if ();

    // Stage 1.
    alu_decode_stage u_decode (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .dec_o   (dec_if.dec_mp)
    );

    // Stage 2.
    alu_execute_stage u_execute (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dec_i   (dec_if.ex_mp),
        .res_o   (res_if.ex_mp)
    );

    // Stage 3.
    alu_flag_stage u_flag (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .res_i    (res_if.flg_mp),
        .valid_o  (valid_o),
        .result_o (result_o),
        .status_o (status_o)
    );

endmodule

// ==== alu_pkg.sv ====
package alu_pkg;

    typedef logic [7:0] word_t;
    typedef logic [3:0] opcode_t;
    typedef logic [3:0] status_t;   // V, Z, C, N from bit 3 down.
    typedef logic [7:0] carry_t;    // Carry out of each adder bit.
    typedef logic [1:0] addb_sel_t;

    // Operation codes, 12 to 15 unused.
    localparam opcode_t OP_NOT    = 4'd0;
    localparam opcode_t OP_AND    = 4'd1;
    localparam opcode_t OP_XNOR   = 4'd2;
    localparam opcode_t OP_LSL    = 4'd3;
    localparam opcode_t OP_ASR    = 4'd4;
    localparam opcode_t OP_ADD    = 4'd5;
    localparam opcode_t OP_SUB    = 4'd6;
    localparam opcode_t OP_INC    = 4'd7;
    localparam opcode_t OP_DEC    = 4'd8;
    localparam opcode_t OP_NEG    = 4'd9;
    localparam opcode_t OP_MULTI8 = 4'd10;
    localparam opcode_t OP_MOD4   = 4'd11;

    localparam int FLAG_V = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 0;

    // Source of the adder b operand.
    localparam addb_sel_t ADDB_B        = 2'd0;
    localparam addb_sel_t ADDB_NOT_B    = 2'd1;
    localparam addb_sel_t ADDB_ONE      = 2'd2;
    localparam addb_sel_t ADDB_ALL_ONES = 2'd3;

endpackage

// ==== alu_res_if.sv ====
interface alu_res_if;

    logic            valid;
    alu_pkg::word_t  result;
    alu_pkg::carry_t carries;
    logic            arith;
    logic            shift;

    modport ex_mp (
        output valid, result, carries, arith, shift
    );

    modport flg_mp (
        input  valid, result, carries, arith, shift
    );

endinterface

// ==== files.f ====
alu_pkg.sv
alu_dec_if.sv
alu_res_if.sv
alu_decode_stage.sv
ripple_adder.sv
alu_execute_stage.sv
alu_flag_stage.sv
alu_pipeline.sv
tb_alu_pipeline.sv

// ==== ripple_adder.sv ====
module ripple_adder (
    input  alu_pkg::word_t  a_i,
    input  alu_pkg::word_t  b_i,
    input  logic            carry_i,
    output alu_pkg::word_t  sum_o,
    output alu_pkg::carry_t carries_o
);

    alu_pkg::carry_t carry_in;   // Carry into each bit.

    assign carry_in = {carries_o[6:0], carry_i};

    // One full-adder cell per bit.
    for (genvar i = 0; i < $bits(alu_pkg::word_t); i++) begin : g_bit
        assign sum_o[i]     = a_i[i] ^ b_i[i] ^ carry_in[i];
        assign carries_o[i] = (a_i[i] & b_i[i])
                            | (a_i[i] & carry_in[i])
                            | (b_i[i] & carry_in[i]);
    end

endmodule

// ==== tb_alu_pipeline.sv ====
module tb_alu_pipeline;

    localparam int MAX_VECTORS = 64;
    localparam int LATENCY     = 3;

    logic              clk_i;
    logic              reset_i;
    logic              valid_i;
    alu_pkg::opcode_t  op_i;
    alu_pkg::word_t    a_i;
    alu_pkg::word_t    b_i;
    logic              valid_o;
    alu_pkg::word_t    result_o;
    alu_pkg::status_t  status_o;

    // Golden vectors.
    alu_pkg::opcode_t  vec_op  [MAX_VECTORS];
    alu_pkg::word_t    vec_a   [MAX_VECTORS];
    alu_pkg::word_t    vec_b   [MAX_VECTORS];
    alu_pkg::word_t    vec_res [MAX_VECTORS];
    alu_pkg::status_t  vec_st  [MAX_VECTORS];
    int                nvec;
    bit                loaded;

    // Operations in flight, oldest first.
    int                due_q [$];
    int                idx_q [$];
    alu_pkg::word_t    res_q [$];
    alu_pkg::status_t  st_q  [$];

    int                cycle;
    int                cur_idx;
    int                checks;
    int                errors;

    alu_pipeline u_alu_pipeline (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .status_o (status_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h (vector %0d)", name, got, exp, cur_idx);
        end
    endtask

    task load_vectors;
        integer           fd;
        integer           code;
        reg [8*80-1:0]    line;
        logic [31:0]      f_op;
        logic [31:0]      f_a;
        logic [31:0]      f_b;
        logic [31:0]      f_res;
        logic [31:0]      f_st;
        fd = $fopen("alu_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Error: could not open alu_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_st);
                    if (code == 5 && nvec < MAX_VECTORS) begin  // Comment lines fail here.
                        vec_op[nvec]  = f_op[3:0];
                        vec_a[nvec]   = f_a[7:0];
                        vec_b[nvec]   = f_b[7:0];
                        vec_res[nvec] = f_res[7:0];
                        vec_st[nvec]  = f_st[3:0];
                        nvec++;
                    end
                end
            end
            $fclose(fd);
            if (nvec == 0) begin
                errors++;
                $display("Error: no vectors found in alu_golden.txt");
            end
        end
    endtask

    // Outputs are sampled on the falling edge, away from register updates.
    task check_outputs;
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            cur_idx = idx_q[0];
            checks++;
            if (valid_o !== 1'b1) begin
                errors++;
                $display("Error: valid_o did not rise for vector %0d at cycle %0d",
                         cur_idx, cycle);
            end else begin
                check_value("result_o", result_o, res_q[0]);
                check_value("status_o", {4'h0, status_o}, {4'h0, st_q[0]});
            end
            void'(due_q.pop_front());
            void'(idx_q.pop_front());
            void'(res_q.pop_front());
            void'(st_q.pop_front());
        end else if (valid_o !== 1'b0) begin
            errors++;
            $display("Error: valid_o was high at cycle %0d with no operation due", cycle);
        end
        if (reset_i) begin     // Outputs read zero in reset.
            check_value("result_o", result_o, 8'h00);
            check_value("status_o", {4'h0, status_o}, 8'h00);
        end
    endtask

    task advance_cycle;
        @(negedge clk_i);
        cycle++;
        check_outputs();
    endtask

    task drive_idle;
        logic [31:0] rnd;
        rnd     = $urandom;
        valid_i = 1'b0;
        op_i    = rnd[3:0];     // Junk operands while idle.
        a_i     = rnd[11:4];
        b_i     = rnd[19:12];
    endtask

    task drive_vector(input int idx);
        valid_i = 1'b1;
        op_i    = vec_op[idx];
        a_i     = vec_a[idx];
        b_i     = vec_b[idx];
        due_q.push_back(cycle + LATENCY);
        idx_q.push_back(idx);
        res_q.push_back(vec_res[idx]);
        st_q.push_back(vec_st[idx]);
    endtask

    initial begin
        wait (loaded);
        #((nvec * 4 + 20) * 4);
        $display("Error: timeout, pipeline still busy at cycle %0d", cycle);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          gap;
        void'($urandom(32'hbf56_4846));
        clk_i   = 1'b0;
        reset_i = 1'b1;
        valid_i = 1'b0;
        op_i    = '0;
        a_i     = '0;
        b_i     = '0;
        nvec    = 0;
        cycle   = 0;
        cur_idx = 0;
        checks  = 0;
        errors  = 0;
        load_vectors();
        loaded = 1'b1;

        repeat (4) advance_cycle();
        reset_i = 1'b0;

        for (int i = 0; i < nvec; i++) begin
            rnd = $urandom;
            gap = rnd[1:0];
            repeat (gap) begin
                advance_cycle();
                drive_idle();
            end
            advance_cycle();
            drive_vector(i);
        end
        advance_cycle();
        drive_idle();

        // Drain, then make sure no stray pulse follows.
        while (due_q.size() > 0) advance_cycle();
        repeat (4) advance_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
